// File: Bender.yml
package:
  name: spu_exec

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/spu_isa_pkg.sv
      - src/spu_pipe_pkg.sv
      - src/spu_exec_if.sv
      - src/spu_decode.sv
      - src/simple_fixed_1.sv
      - src/simple_fixed_2.sv
      - src/spu_writeback.sv
      - src/spu_exec.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/spu_exec_assert.sv
      - bench/spu_exec_tb.sv

// File: bench/spu_exec_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "spu_defs.svh"

module spu_exec_assert import spu_isa_pkg::*, spu_pipe_pkg::*; (
	input wire                    clk,
	input wire                    reset,
	input wire [`SPU_INSTR_W-1:0] instr,
	input wire                    instr_valid,
	input wire                    iss_write,     // Decoder write flag at issue
	input wire                    reg_write_wb,
	input wire spu_reg_t          rt_wb,
	input wire spu_addr_t         rt_addr_wb,
	input wire                    illegal
);

	int   fail_cnt = 0;  // Read by the testbench at the end
	logic [10:0] opc_rr;    // Top bits as an RR opcode
	logic [7:0]  opc_ri10;  // and as an RI10 opcode
	logic        known_opc;
	logic        bad_issue;

	assign opc_rr   = instr[`SPU_INSTR_W-1 -: 11];
	assign opc_ri10 = instr[`SPU_INSTR_W-1 -: 8];

	// Zero word or an opcode from either table
	assign known_opc = (instr == '0) ||
		(opc_rr inside {OPC_AH, OPC_A, OPC_SFH, OPC_SF, OPC_AND, OPC_OR, OPC_XOR,
			OPC_SHLH, OPC_SHL}) ||
		(opc_ri10 inside {OPC_AHI, OPC_AI, OPC_SHLHI, OPC_SHLI, OPC_ROTI});

	// Valid word whose opcode is in neither table
	assign bad_issue = instr_valid && !known_opc;

	// One write per issued instruction, three edges later
	write_delay: assert property (@(posedge clk) disable iff (reset)
		reg_write_wb == $past(iss_write, 3)) else begin
		fail_cnt++;
		$error("Write port out of step with the issued write flag");
	end

	illegal_next: assert property (@(posedge clk) disable iff (reset)
		illegal == $past(bad_issue)) else begin
		fail_cnt++;
		$error("Illegal flag does not follow the unknown opcode by one cycle");
	end

	illegal_no_write: assert property (@(posedge clk) disable iff (reset)
		bad_issue |-> ##3 !reg_write_wb) else begin
		fail_cnt++;
		$error("Unknown opcode produced a register write");
	end

	idle_zero: assert property (@(posedge clk) disable iff (reset)
		!reg_write_wb |-> (rt_wb == '0 && rt_addr_wb == '0)) else begin
		fail_cnt++;
		$error("Idle write port shows nonzero data or address");
	end

endmodule

`default_nettype wire

// File: bench/spu_exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "spu_defs.svh"

module spu_exec_tb import spu_isa_pkg::*, spu_pipe_pkg::*; ();

	localparam int N_SF1   = 300;  // Arithmetic and logical instructions
	localparam int N_SF2   = 150;  // Shifts and rotates
	localparam int N_ALT   = 100;  // Units alternate every cycle
	localparam int N_MISC  = 40;   // NOPs, idle cycles, unknown opcodes
	localparam int N_ISSUE = N_SF1 + N_SF2 + N_ALT + N_MISC + 4;  // Plus drain
	localparam int LIMIT   = N_ISSUE + 20;

	localparam spu_op_e SF1_OPS [9] = '{AH, A, SFH, SF, AND, OR, XOR, AHI, AI};
	localparam spu_op_e SF2_OPS [5] = '{SHLH, SHL, SHLHI, SHLI, ROTI};

	// One expected write port state
	typedef struct packed {
		logic      wr;
		spu_addr_t addr;
		spu_reg_t  rt;
	} wb_exp_t;

	logic                    clk;
	logic                    reset;
	logic [`SPU_INSTR_W-1:0] instr;
	logic                    instr_valid;
	spu_reg_t                ra, rb;
	spu_addr_t               ra_addr, rb_addr;
	spu_reg_t                rt_wb;
	spu_addr_t               rt_addr_wb;
	logic                    reg_write_wb;
	logic                    illegal;

	spu_reg_t regs [1 << `SPU_ADDR_W];  // Model register file
	wb_exp_t  exp_q [$];                 // One entry per issue slot
	logic     exp_illegal;               // Expected illegal for the next cycle
	int       err_cnt;
	int       cycles;

	always #5 clk = ~clk;

	assign ra = regs[ra_addr];  // Read ports answer in the same cycle
	assign rb = regs[rb_addr];

	always @(posedge clk) begin
		if (reg_write_wb)
			regs[rt_addr_wb] <= rt_wb;
	end

	spu_exec dut_i (
		.clk          (clk),
		.reset        (reset),
		.instr        (instr),
		.instr_valid  (instr_valid),
		.ra           (ra),
		.rb           (rb),
		.ra_addr      (ra_addr),
		.rb_addr      (rb_addr),
		.rt_wb        (rt_wb),
		.rt_addr_wb   (rt_addr_wb),
		.reg_write_wb (reg_write_wb),
		.illegal      (illegal)
	);

	bind spu_exec spu_exec_assert assert_i (
		.clk          (clk),
		.reset        (reset),
		.instr        (instr),
		.instr_valid  (instr_valid),
		.iss_write    (iss.reg_write),
		.reg_write_wb (reg_write_wb),
		.rt_wb        (rt_wb),
		.rt_addr_wb   (rt_addr_wb),
		.illegal      (illegal)
	);

	function automatic logic [31:0] encode(input spu_op_e op, input spu_addr_t rt,
			input spu_addr_t ra_f, input spu_addr_t rb_f, input logic [9:0] i10);
		case (op)
			AH:      return {OPC_AH, rb_f, ra_f, rt};
			A:       return {OPC_A, rb_f, ra_f, rt};
			SFH:     return {OPC_SFH, rb_f, ra_f, rt};
			SF:      return {OPC_SF, rb_f, ra_f, rt};
			AND:     return {OPC_AND, rb_f, ra_f, rt};
			OR:      return {OPC_OR, rb_f, ra_f, rt};
			XOR:     return {OPC_XOR, rb_f, ra_f, rt};
			SHLH:    return {OPC_SHLH, rb_f, ra_f, rt};
			SHL:     return {OPC_SHL, rb_f, ra_f, rt};
			AHI:     return {OPC_AHI, i10, ra_f, rt};
			AI:      return {OPC_AI, i10, ra_f, rt};
			SHLHI:   return {OPC_SHLHI, i10, ra_f, rt};
			SHLI:    return {OPC_SHLI, i10, ra_f, rt};
			ROTI:    return {OPC_ROTI, i10, ra_f, rt};
			default: return '0;  // NOP
		endcase
	endfunction

	// One lane of width w, zero-extended into 32 bits
	function automatic logic [31:0] lane_op(input spu_op_e op, input logic [31:0] x,
			input logic [31:0] y, input logic [9:0] i10, input int w);
		logic [31:0] s;
		logic [31:0] m;
		int          n;
		s = {{22{i10[9]}}, i10};
		m = (w == 16) ? 32'h0000_ffff : 32'hffff_ffff;
		case (op)
			SHLH:        n = y[4:0];
			SHL:         n = y[5:0];
			SHLHI, ROTI: n = i10[4:0];
			SHLI:        n = i10[5:0];
			default:     n = 0;
		endcase
		case (op)
			AH, A:   return (x + y) & m;
			SFH, SF: return (y - x) & m;  // Subtract from
			AHI, AI: return (x + s) & m;
			ROTI:    return (x << n) | (x >> (32 - n));
			default: return (n >= w) ? 32'h0 : ((x << n) & m);
		endcase
	endfunction

	function automatic spu_reg_t model(input spu_op_e op, input spu_reg_t a,
			input spu_reg_t b, input logic [9:0] i10);
		spu_reg_t r;
		r = '0;
		case (op)
			AND: r = a & b;
			OR:  r = a | b;
			XOR: r = a ^ b;
			AH, SFH, AHI, SHLH, SHLHI:
				for (int k = 0; k < `SPU_HW_LANES; k++)
					r[16*k +: 16] = 16'(lane_op(op, a[16*k +: 16], b[16*k +: 16], i10, 16));
			A, SF, AI, SHL, SHLI, ROTI:
				for (int k = 0; k < `SPU_W_LANES; k++)
					r[32*k +: 32] = lane_op(op, a[32*k +: 32], b[32*k +: 32], i10, 32);
			default: r = '0;
		endcase
		return r;
	endfunction

	task automatic check_outputs();
		wb_exp_t e;
		assert (illegal == exp_illegal) else begin
			err_cnt++;
			$display("ERR illegal got %h exp %h", illegal, exp_illegal);
		end
		if (exp_q.size() > 0) begin
			e = exp_q.pop_front();
			assert (reg_write_wb == e.wr) else begin
				err_cnt++;
				$display("ERR reg_write_wb got %h exp %h", reg_write_wb, e.wr);
			end
			assert (rt_addr_wb == e.addr) else begin
				err_cnt++;
				$display("ERR rt_addr_wb got %h exp %h", rt_addr_wb, e.addr);
			end
			assert (rt_wb == e.rt) else begin
				err_cnt++;
				$display("ERR rt_wb got %h exp %h", rt_wb, e.rt);
			end
		end
	endtask

	// One issue slot: check the port, drive the next word, queue its result
	task automatic step(input spu_op_e op, input logic valid, input logic bad);
		spu_addr_t  f_rt, f_ra, f_rb;
		logic [9:0] i10;
		wb_exp_t    e;
		f_rt = $urandom;
		f_ra = $urandom;
		f_rb = $urandom;
		i10  = $urandom;
		if ($urandom_range(3) == 0)
			i10[5:0] = ($urandom_range(1) == 0) ? 6'd16 : 6'd32;  // Counts at lane width
		@(posedge clk);
		#1;
		check_outputs();
		instr       = bad ? {8'hff, i10, f_ra, f_rt} : encode(op, f_rt, f_ra, f_rb, i10);
		instr_valid = valid;
		#1;
		if (!bad && op != NOP) begin  // Read addresses follow the instruction word
			assert (ra_addr == f_ra) else begin
				err_cnt++;
				$display("ERR ra_addr got %h exp %h", ra_addr, f_ra);
			end
			if (op inside {AH, A, SFH, SF, AND, OR, XOR, SHLH, SHL}) begin
				assert (rb_addr == f_rb) else begin
					err_cnt++;
					$display("ERR rb_addr got %h exp %h", rb_addr, f_rb);
				end
			end
		end
		e.wr   = valid && !bad && (op != NOP);
		e.addr = e.wr ? f_rt : '0;
		e.rt   = e.wr ? model(op, regs[f_ra], regs[f_rb], i10) : '0;
		exp_q.push_back(e);
		exp_illegal = valid && bad;
	endtask

	initial begin
		void'($urandom(27779));
		clk         = 1'b0;
		reset       = 1'b1;
		instr       = '0;
		instr_valid = 1'b0;
		exp_illegal = 1'b0;
		err_cnt     = 0;
		foreach (regs[i])
			regs[i] = {$urandom, $urandom, $urandom, $urandom};
		repeat (3)
			exp_q.push_back('0);  // Pipe still holds reset state
		repeat (8) @(posedge clk);
		#1 reset = 1'b0;
		repeat (N_SF1) step(SF1_OPS[$urandom_range(8)], 1'b1, 1'b0);
		repeat (N_SF2) step(SF2_OPS[$urandom_range(4)], 1'b1, 1'b0);
		for (int k = 0; k < N_ALT; k++)
			step((k % 2) ? SF2_OPS[$urandom_range(4)] : SF1_OPS[$urandom_range(8)], 1'b1, 1'b0);
		for (int k = 0; k < N_MISC; k++)  // NOP, idle, unknown, shift in turn
			step((k % 4 == 0) ? NOP : (k % 4 == 3) ? SF2_OPS[$urandom_range(4)] :
				SF1_OPS[$urandom_range(8)], k % 4 != 1, k % 4 == 2);
		repeat (4) step(NOP, 1'b0, 1'b0);  // Drain
		$display("Errors: %0d value checks, %0d assertions", err_cnt,
			dut_i.assert_i.fail_cnt);
		if (err_cnt == 0 && dut_i.assert_i.fail_cnt == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < LIMIT) begin
			@(posedge clk);
			if (!reset)
				cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", LIMIT);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+src
src/spu_isa_pkg.sv
src/spu_pipe_pkg.sv
src/spu_exec_if.sv
src/spu_decode.sv
src/simple_fixed_1.sv
src/simple_fixed_2.sv
src/spu_writeback.sv
src/spu_exec.sv
bench/spu_exec_assert.sv
bench/spu_exec_tb.sv

// File: src/simple_fixed_1.sv
`timescale 1ns/1ps
`default_nettype none

`include "spu_defs.svh"

module simple_fixed_1 import spu_isa_pkg::*, spu_pipe_pkg::*; (
	input  wire        clk,
	input  wire        reset,
	issue_if.unit      iss,
	result_if.producer res
);

	// Lane views of the operands
	spu_hw_vec_t a_h, b_h, r_h;
	spu_w_vec_t  a_w, b_w, r_w;
	logic [15:0] imm_h;   // Immediate widened to one halfword lane
	logic [31:0] imm_w;   // and to one word lane

	logic      mine;      // Instruction routed here
	spu_reg_t  calc;
	spu_reg_t  rt_d;
	spu_addr_t addr_d;
	logic      wr_d;

	// Stage registers, index 0 first
	spu_reg_t  [`SPU_PIPE_DEPTH-1:0] rt_q;
	spu_addr_t [`SPU_PIPE_DEPTH-1:0] addr_q;
	logic      [`SPU_PIPE_DEPTH-1:0] wr_q;

	assign a_h   = iss.ra;
	assign b_h   = iss.rb;
	assign a_w   = iss.ra;
	assign b_w   = iss.rb;
	assign imm_h = iss.imm[15:0];
	assign imm_w = {{14{iss.imm[17]}}, iss.imm};

	// Lane sums wrap as two's complement
	always_comb begin
		r_h  = '0;
		r_w  = '0;
		calc = '0;
		case (iss.op)
			AH: begin
				for (int i = 0; i < `SPU_HW_LANES; i++)
					r_h[i] = a_h[i] + b_h[i];
				calc = r_h;
			end
			A: begin
				for (int i = 0; i < `SPU_W_LANES; i++)
					r_w[i] = a_w[i] + b_w[i];
				calc = r_w;
			end
			SFH: begin  // rb minus ra
				for (int i = 0; i < `SPU_HW_LANES; i++)
					r_h[i] = b_h[i] - a_h[i];
				calc = r_h;
			end
			SF: begin
				for (int i = 0; i < `SPU_W_LANES; i++)
					r_w[i] = b_w[i] - a_w[i];
				calc = r_w;
			end
			AND: calc = iss.ra & iss.rb;  // Whole word, no lanes
			OR:  calc = iss.ra | iss.rb;
			XOR: calc = iss.ra ^ iss.rb;
			AHI: begin
				for (int i = 0; i < `SPU_HW_LANES; i++)
					r_h[i] = a_h[i] + imm_h;
				calc = r_h;
			end
			AI: begin
				for (int i = 0; i < `SPU_W_LANES; i++)
					r_w[i] = a_w[i] + imm_w;
				calc = r_w;
			end
			default: calc = '0;
		endcase
	end

	// Bubble with zero result when another unit owns the slot
	assign mine   = (iss.sel == UNIT_SF1);
	assign wr_d   = mine && iss.reg_write;
	assign rt_d   = mine ? calc : '0;
	assign addr_d = mine ? iss.rt_addr : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			rt_q   <= '0;
			addr_q <= '0;
			wr_q   <= '0;
		end else begin
			rt_q   <= {rt_q[`SPU_PIPE_DEPTH-2:0], rt_d};  // Shift one stage on
			addr_q <= {addr_q[`SPU_PIPE_DEPTH-2:0], addr_d};
			wr_q   <= {wr_q[`SPU_PIPE_DEPTH-2:0], wr_d};
		end
	end

	assign res.rt        = rt_q[`SPU_PIPE_DEPTH-1];
	assign res.rt_addr   = addr_q[`SPU_PIPE_DEPTH-1];
	assign res.reg_write = wr_q[`SPU_PIPE_DEPTH-1];

endmodule

`default_nettype wire

// File: src/simple_fixed_2.sv
`timescale 1ns/1ps
`default_nettype none

`include "spu_defs.svh"

module simple_fixed_2 import spu_isa_pkg::*, spu_pipe_pkg::*; (
	input  wire        clk,
	input  wire        reset,
	issue_if.unit      iss,
	result_if.producer res
);

	spu_hw_vec_t a_h, b_h, r_h;
	spu_w_vec_t  a_w, b_w, r_w;

	logic      mine;
	spu_reg_t  rt_d;
	spu_addr_t addr_d;
	logic      wr_d;

	spu_reg_t  [`SPU_PIPE_DEPTH-1:0] rt_q;
	spu_addr_t [`SPU_PIPE_DEPTH-1:0] addr_q;
	logic      [`SPU_PIPE_DEPTH-1:0] wr_q;

	// Count of 16 or more clears the lane
	function automatic logic [15:0] shl_h(input logic [15:0] v, input logic [4:0] n);
		return (n >= 5'd16) ? 16'h0 : (v << n);
	endfunction

	// Six count bits, so 32 to 63 clear the lane
	function automatic logic [31:0] shl_w(input logic [31:0] v, input logic [5:0] n);
		return (n >= 6'd32) ? 32'h0 : (v << n);
	endfunction

	function automatic logic [31:0] rotl_w(input logic [31:0] v, input logic [4:0] n);
		logic [63:0] dbl;
		dbl = {v, v} << n;  // Upper half holds the rotated word
		return dbl[63:32];
	endfunction

	assign a_h = iss.ra;
	assign b_h = iss.rb;
	assign a_w = iss.ra;
	assign b_w = iss.rb;

	always_comb begin
		r_h  = '0;
		r_w  = '0;
		rt_d = '0;
		case (iss.op)
			SHLH: begin  // Count from the matching rb lane
				for (int i = 0; i < `SPU_HW_LANES; i++)
					r_h[i] = shl_h(a_h[i], b_h[i][4:0]);
				rt_d = r_h;
			end
			SHL: begin
				for (int i = 0; i < `SPU_W_LANES; i++)
					r_w[i] = shl_w(a_w[i], b_w[i][5:0]);
				rt_d = r_w;
			end
			SHLHI: begin
				for (int i = 0; i < `SPU_HW_LANES; i++)
					r_h[i] = shl_h(a_h[i], iss.imm[4:0]);
				rt_d = r_h;
			end
			SHLI: begin
				for (int i = 0; i < `SPU_W_LANES; i++)
					r_w[i] = shl_w(a_w[i], iss.imm[5:0]);
				rt_d = r_w;
			end
			ROTI: begin  // Modulo 32 from the low imm bits
				for (int i = 0; i < `SPU_W_LANES; i++)
					r_w[i] = rotl_w(a_w[i], iss.imm[4:0]);
				rt_d = r_w;
			end
			default: rt_d = '0;
		endcase
		if (!mine)
			rt_d = '0;  // Bubble
	end

	assign mine   = (iss.sel == UNIT_SF2);
	assign wr_d   = mine && iss.reg_write;
	assign addr_d = mine ? iss.rt_addr : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			rt_q   <= '0;
			addr_q <= '0;
			wr_q   <= '0;
		end else begin
			rt_q   <= {rt_q[`SPU_PIPE_DEPTH-2:0], rt_d};
			addr_q <= {addr_q[`SPU_PIPE_DEPTH-2:0], addr_d};
			wr_q   <= {wr_q[`SPU_PIPE_DEPTH-2:0], wr_d};
		end
	end

	assign res.rt        = rt_q[`SPU_PIPE_DEPTH-1];
	assign res.rt_addr   = addr_q[`SPU_PIPE_DEPTH-1];
	assign res.reg_write = wr_q[`SPU_PIPE_DEPTH-1];

endmodule

`default_nettype wire

// File: src/spu_decode.sv
`timescale 1ns/1ps
`default_nettype none

module spu_decode import spu_isa_pkg::*, spu_pipe_pkg::*; (
	input  wire             clk,
	input  wire             reset,
	input  wire spu_instr_u instr,
	input  wire             instr_valid,
	output spu_addr_t       ra_addr,
	output spu_addr_t       rb_addr,
	output logic            illegal,  // Unknown opcode, one cycle late
	issue_if.decoder        iss,
	input  wire spu_reg_t   ra,
	input  wire spu_reg_t   rb
);

	spu_op_e     dec_op;
	spu_format_e fmt;
	logic        known;   // Opcode matched a table entry
	spu_unit_e   unit;

	// RR table first, then the 8-bit RI10 field
	always_comb begin
		dec_op = NOP;
		fmt    = FMT_RR;
		known  = 1'b1;
		if (instr != '0) begin  // All-zero word is the NOP
			case (instr.rr.opcode)
				OPC_AH:   dec_op = AH;
				OPC_A:    dec_op = A;
				OPC_SFH:  dec_op = SFH;
				OPC_SF:   dec_op = SF;
				OPC_AND:  dec_op = AND;
				OPC_OR:   dec_op = OR;
				OPC_XOR:  dec_op = XOR;
				OPC_SHLH: dec_op = SHLH;
				OPC_SHL:  dec_op = SHL;
				default: begin
					fmt = FMT_RI10;
					case (instr.ri10.opcode)
						OPC_AHI:   dec_op = AHI;
						OPC_AI:    dec_op = AI;
						OPC_SHLHI: dec_op = SHLHI;
						OPC_SHLI:  dec_op = SHLI;
						OPC_ROTI:  dec_op = ROTI;
						default:   known = 1'b0;  // Falls through as NOP
					endcase
				end
			endcase
		end
	end

	// Arithmetic and logic to unit 1, shifts and rotates to unit 2
	always_comb begin
		case (dec_op)
			AH, A, SFH, SF, AND, OR, XOR, AHI, AI: unit = UNIT_SF1;
			SHLH, SHL, SHLHI, SHLI, ROTI:         unit = UNIT_SF2;
			default:                              unit = UNIT_NONE;
		endcase
	end

	// Register addresses out to the external register file
	assign ra_addr = instr.rr.ra;  // Same bits in both layouts
	assign rb_addr = (fmt == FMT_RR) ? instr.rr.rb : '0;  // No rb in RI10

	assign iss.op        = instr_valid ? dec_op : NOP;
	assign iss.sel       = instr_valid ? unit : UNIT_NONE;
	assign iss.reg_write = instr_valid && (unit != UNIT_NONE);
	assign iss.rt_addr   = instr.rr.rt;
	assign iss.imm       = (fmt == FMT_RI10) ?
		{{8{instr.ri10.i10[9]}}, instr.ri10.i10} : '0;  // Sign extend to 18 bits
	assign iss.ra        = ra;  // Operands come back in the same cycle
	assign iss.rb        = rb;

	always_ff @(posedge clk) begin
		if (reset) begin
			illegal <= 1'b0;
		end else begin
			illegal <= instr_valid && !known;
		end
	end

endmodule

`default_nettype wire

// File: src/spu_defs.svh
`ifndef SPU_DEFS_SVH
`define SPU_DEFS_SVH

// Register word and lane geometry
`define SPU_REG_W       128     // Full register width
`define SPU_HW_LANES    8       // 16-bit lanes per word
`define SPU_W_LANES     4       // 32-bit lanes per word

// Register file addressing
`define SPU_ADDR_W      7       // 128 registers

// Instruction word
`define SPU_INSTR_W     32

// Register stages inside each execution unit
`define SPU_PIPE_DEPTH  2

`endif

// File: src/spu_exec.sv
`timescale 1ns/1ps
`default_nettype none

`include "spu_defs.svh"

module spu_exec import spu_pipe_pkg::*; (
	input  wire                    clk,
	input  wire                    reset,
	input  wire [`SPU_INSTR_W-1:0] instr,
	input  wire                    instr_valid,
	input  wire spu_reg_t          ra,          // Register file read data
	input  wire spu_reg_t          rb,
	output spu_addr_t              ra_addr,     // Register file read addresses
	output spu_addr_t              rb_addr,
	output spu_reg_t               rt_wb,       // Write port, three cycles after issue
	output spu_addr_t              rt_addr_wb,
	output logic                   reg_write_wb,
	output logic                   illegal
);

	issue_if  iss ();
	result_if sf1_res ();
	result_if sf2_res ();

	spu_decode decode_i (
		.clk         (clk),
		.reset       (reset),
		.instr       (instr),
		.instr_valid (instr_valid),
		.ra_addr     (ra_addr),
		.rb_addr     (rb_addr),
		.illegal     (illegal),
		.iss         (iss.decoder),
		.ra          (ra),
		.rb          (rb)
	);

	// Arithmetic and logical unit
	simple_fixed_1 sf1_i (
		.clk   (clk),
		.reset (reset),
		.iss   (iss.unit),
		.res   (sf1_res.producer)
	);

	// Shift and rotate unit
	simple_fixed_2 sf2_i (
		.clk   (clk),
		.reset (reset),
		.iss   (iss.unit),
		.res   (sf2_res.producer)
	);

	spu_writeback wb_i (
		.clk          (clk),
		.reset        (reset),
		.sf1          (sf1_res.consumer),
		.sf2          (sf2_res.consumer),
		.rt_wb        (rt_wb),
		.rt_addr_wb   (rt_addr_wb),
		.reg_write_wb (reg_write_wb)
	);

endmodule

`default_nettype wire

// File: src/spu_exec_if.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded instruction with its operands, from decoder to both units
interface issue_if import spu_isa_pkg::*, spu_pipe_pkg::*; ();

	spu_op_e    op;         // Decoded operation
	logic [17:0] imm;       // Sign-extended immediate
	spu_addr_t  rt_addr;    // Destination register
	spu_reg_t   ra;         // Operand values from the register file
	spu_reg_t   rb;
	logic       reg_write;  // Instruction writes rt
	spu_unit_e  sel;        // Target unit

	modport decoder (
		output op, imm, rt_addr, ra, rb, reg_write, sel
	);

	modport unit (
		input op, imm, rt_addr, ra, rb, reg_write, sel
	);

endinterface

// One unit's final stage, read by writeback
interface result_if import spu_pipe_pkg::*; ();

	spu_reg_t  rt;
	spu_addr_t rt_addr;
	logic      reg_write;

	modport producer (
		output rt, rt_addr, reg_write
	);

	modport consumer (
		input rt, rt_addr, reg_write
	);

endinterface

`default_nettype wire

// File: src/spu_isa_pkg.sv
`default_nettype none

`include "spu_defs.svh"

package spu_isa_pkg;

	// RR opcodes, 11 bits
	localparam logic [10:0] OPC_AH   = 11'b00011001000;  // Add halfword
	localparam logic [10:0] OPC_A    = 11'b00011000000;  // Add word
	localparam logic [10:0] OPC_SFH  = 11'b00001001000;  // Subtract from halfword
	localparam logic [10:0] OPC_SF   = 11'b00001000000;  // Subtract from word
	localparam logic [10:0] OPC_AND  = 11'b00011000001;
	localparam logic [10:0] OPC_OR   = 11'b00001000001;
	localparam logic [10:0] OPC_XOR  = 11'b01001000001;
	localparam logic [10:0] OPC_SHLH = 11'b00001011111;  // Shift left halfword by rb
	localparam logic [10:0] OPC_SHL  = 11'b00001011011;  // Shift left word by rb

	// RI10 opcodes, 8 bits
	localparam logic [7:0] OPC_AHI   = 8'b00011101;
	localparam logic [7:0] OPC_AI    = 8'b00011100;
	localparam logic [7:0] OPC_SHLHI = 8'b00001111;
	localparam logic [7:0] OPC_SHLI  = 8'b00001110;
	localparam logic [7:0] OPC_ROTI  = 8'b00001100;      // Rotate word left by imm

	// Register-register layout, opcode in the top bits
	typedef struct packed {
		logic [10:0]            opcode;
		logic [`SPU_ADDR_W-1:0] rb;
		logic [`SPU_ADDR_W-1:0] ra;
		logic [`SPU_ADDR_W-1:0] rt;
	} spu_rr_t;

	// Register-immediate layout with 10-bit signed immediate
	typedef struct packed {
		logic [7:0]             opcode;
		logic [9:0]             i10;
		logic [`SPU_ADDR_W-1:0] ra;
		logic [`SPU_ADDR_W-1:0] rt;
	} spu_ri10_t;

	// Same 32 bits, read either way by the decoder
	typedef union packed {
		spu_rr_t   rr;
		spu_ri10_t ri10;
	} spu_instr_u;

	typedef enum logic {
		FMT_RR,
		FMT_RI10
	} spu_format_e;

	typedef enum logic [3:0] {
		NOP, AH, A, SFH, SF, AND, OR, XOR,
		AHI, AI, SHLH, SHL, SHLHI, SHLI, ROTI
	} spu_op_e;

endpackage

`default_nettype wire

// File: src/spu_pipe_pkg.sv
`default_nettype none

`include "spu_defs.svh"

package spu_pipe_pkg;

	// Which execution unit takes the instruction
	typedef enum logic [1:0] {
		UNIT_NONE,
		UNIT_SF1,
		UNIT_SF2
	} spu_unit_e;

	typedef logic [`SPU_REG_W-1:0]  spu_reg_t;   // Whole register word
	typedef logic [`SPU_ADDR_W-1:0] spu_addr_t;  // Register number

	// Lane views of one register word, lane 0 in the low bits
	typedef logic [`SPU_HW_LANES-1:0][15:0] spu_hw_vec_t;
	typedef logic [`SPU_W_LANES-1:0][31:0]  spu_w_vec_t;

endpackage

`default_nettype wire

// File: src/spu_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module spu_writeback import spu_pipe_pkg::*; (
	input  wire        clk,
	input  wire        reset,
	result_if.consumer sf1,
	result_if.consumer sf2,
	output spu_reg_t   rt_wb,
	output spu_addr_t  rt_addr_wb,
	output logic       reg_write_wb
);

	spu_unit_e src;  // Unit whose result is written this cycle

	// Equal unit depths leave at most one writer per cycle
	always_comb begin
		if (sf1.reg_write)
			src = UNIT_SF1;
		else if (sf2.reg_write)
			src = UNIT_SF2;
		else
			src = UNIT_NONE;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rt_wb        <= '0;
			rt_addr_wb   <= '0;
			reg_write_wb <= 1'b0;
		end else begin
			case (src)
				UNIT_SF1: begin
					rt_wb        <= sf1.rt;
					rt_addr_wb   <= sf1.rt_addr;
					reg_write_wb <= 1'b1;
				end
				UNIT_SF2: begin
					rt_wb        <= sf2.rt;
					rt_addr_wb   <= sf2.rt_addr;
					reg_write_wb <= 1'b1;
				end
				default: begin  // Idle slot reads as zeros
					rt_wb        <= '0;
					rt_addr_wb   <= '0;
					reg_write_wb <= 1'b0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire
